// ==== verilog/tlb_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb defines
// sizes and bus field positions for the
// eight-entry translation lookaside buffer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// table geometry.
`define TLB_ENTRIES   8
`define TLB_IDX_W     3
`define TLB_PN_W      20
`define TLB_RD_PORTS  3

// wishbone word address and data.
`define TLB_WB_ADR_W     4
`define TLB_WB_DAT_W     32
`define TLB_WB_HALF_BIT  0
`define TLB_WB_IDX_LSB   1

// flag bits in the high-half word.
`define TLB_FLAG_VALID  23
`define TLB_FLAG_PR     22
`define TLB_FLAG_RW     21
`define TLB_FLAG_PCD    20

`endif

// ==== verilog/tlb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb_pkg
// types shared by the tlb table, lookup lanes
// and the wishbone slave.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

package tlb_pkg;

  // virtual and physical page numbers share one type.
  typedef logic [`TLB_PN_W-1:0] page_num_t;

  // entry index into the table.
  typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one 44-bit entry with the tag in the top bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    page_num_t vpn;
    page_num_t ppn;
    logic      valid;
    logic      pr;
    logic      rw;
    logic      pcd;
  } tlb_entry_t;

endpackage

// ==== verilog/tlb_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb_table
// eight entries with word-wise write, exported
// tags and valid bits, three read ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

module tlb_table (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wr_en,
  input  tlb_pkg::tlb_idx_t        wr_idx,
  input  logic                     wr_half,
  input  logic [`TLB_WB_DAT_W-1:0] wr_data,
  input  tlb_pkg::tlb_idx_t        rd_idx    [`TLB_RD_PORTS],
  output tlb_pkg::tlb_entry_t      rd_entry  [`TLB_RD_PORTS],
  output tlb_pkg::page_num_t       vpn_all   [`TLB_ENTRIES],
  output logic [`TLB_ENTRIES-1:0]  valid_all
);

  import tlb_pkg::*;

  tlb_entry_t entries [`TLB_ENTRIES];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // half 0 is the tag, half 1 is ppn plus flags.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_en) begin
      if (!wr_half) begin
        entries[wr_idx].vpn <= wr_data[`TLB_PN_W-1:0];
      end else begin
        entries[wr_idx].ppn   <= wr_data[`TLB_PN_W-1:0];
        entries[wr_idx].valid <= wr_data[`TLB_FLAG_VALID];
        entries[wr_idx].pr    <= wr_data[`TLB_FLAG_PR];
        entries[wr_idx].rw    <= wr_data[`TLB_FLAG_RW];
        entries[wr_idx].pcd   <= wr_data[`TLB_FLAG_PCD];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tag export
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // every tag and valid bit goes out for the match logic.
  always_comb begin
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      vpn_all[i]   = entries[i].vpn;
      valid_all[i] = entries[i].valid;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // independent combinational muxes.
  always_comb begin
    for (int p = 0; p < `TLB_RD_PORTS; p++) begin
      rd_entry[p] = entries[rd_idx[p]];
    end
  end

endmodule

// ==== verilog/tlb_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb_lookup
// one lookup lane, registered request, tag match
// with lowest-index priority and permission check.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

module tlb_lookup (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    req_valid,
  input  tlb_pkg::page_num_t      req_vpn,
  input  logic                    req_write,
  input  tlb_pkg::page_num_t      vpn_all [`TLB_ENTRIES],
  input  logic [`TLB_ENTRIES-1:0] valid_all,
  output tlb_pkg::tlb_idx_t       rd_idx,
  input  tlb_pkg::tlb_entry_t     rd_entry,
  output logic                    rsp_valid,
  output logic                    rsp_hit,
  output logic                    rsp_fault,
  output tlb_pkg::page_num_t      rsp_ppn,
  output logic                    rsp_pcd
);

  import tlb_pkg::*;

  logic                    valid_q;
  page_num_t               vpn_q;
  logic                    write_q;
  logic [`TLB_ENTRIES-1:0] match;
  tlb_idx_t                sel_idx;
  logic                    hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid;
    end
  end

  // payload registers load on every edge.
  always_ff @(posedge clk) begin
    vpn_q   <= req_vpn;
    write_q <= req_write;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // match and select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // compare against the live table.
  always_comb begin
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      match[i] = valid_all[i] && (vpn_all[i] == vpn_q);
    end
  end

  // walk down so the lowest index wins.
  always_comb begin
    sel_idx = '0;
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        sel_idx = tlb_idx_t'(i);
      end
    end
  end

  assign hit    = |match;
  assign rd_idx = sel_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rsp_valid = valid_q;
  assign rsp_hit   = hit;

  // miss, not present, or write to a read-only page.
  assign rsp_fault = !hit || !rd_entry.pr || (write_q && !rd_entry.rw);

  // zero on a miss.
  assign rsp_ppn = hit ? rd_entry.ppn : '0;
  assign rsp_pcd = hit && rd_entry.pcd;

endmodule

// ==== verilog/tlb_wb_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb_wb_slave
// wishbone classic slave for writing and reading
// back tlb entries, two words per entry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

module tlb_wb_slave (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`TLB_WB_ADR_W-1:0] wb_adr,
  input  logic [`TLB_WB_DAT_W-1:0] wb_dat_w,
  output logic [`TLB_WB_DAT_W-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic                     wr_en,
  output tlb_pkg::tlb_idx_t        wr_idx,
  output logic                     wr_half,
  output logic [`TLB_WB_DAT_W-1:0] wr_data,
  output tlb_pkg::tlb_idx_t        rd_idx,
  input  tlb_pkg::tlb_entry_t      rd_entry
);

  import tlb_pkg::*;

  tlb_idx_t adr_idx;
  logic     adr_half;

  // word address is index times two plus half.
  assign adr_idx  = wb_adr[`TLB_WB_IDX_LSB +: `TLB_IDX_W];
  assign adr_half = wb_adr[`TLB_WB_HALF_BIT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // single-cycle ack one cycle after the strobe.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  // write lands on the edge closing the ack cycle.
  assign wr_en   = wb_ack && wb_we;
  assign wr_idx  = adr_idx;
  assign wr_half = adr_half;
  assign wr_data = wb_dat_w;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read-back
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_idx = adr_idx;

  // unused bits stay zero.
  always_comb begin
    wb_dat_r = '0;
    if (!adr_half) begin
      wb_dat_r[`TLB_PN_W-1:0] = rd_entry.vpn;
    end else begin
      wb_dat_r[`TLB_PN_W-1:0]   = rd_entry.ppn;
      wb_dat_r[`TLB_FLAG_VALID] = rd_entry.valid;
      wb_dat_r[`TLB_FLAG_PR]    = rd_entry.pr;
      wb_dat_r[`TLB_FLAG_RW]    = rd_entry.rw;
      wb_dat_r[`TLB_FLAG_PCD]   = rd_entry.pcd;
    end
  end

endmodule

// ==== verilog/tlb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb_top
// tlb storage, two lookup lanes and the bus slave.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

module tlb_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`TLB_WB_ADR_W-1:0] wb_adr,
  input  logic [`TLB_WB_DAT_W-1:0] wb_dat_w,
  output logic [`TLB_WB_DAT_W-1:0] wb_dat_r,
  output logic                     wb_ack,
  input  logic                     lookup_a_valid,
  input  tlb_pkg::page_num_t       lookup_a_vpn,
  input  logic                     lookup_a_write,
  output logic                     result_a_valid,
  output logic                     result_a_hit,
  output logic                     result_a_fault,
  output tlb_pkg::page_num_t       result_a_ppn,
  output logic                     result_a_pcd,
  input  logic                     lookup_b_valid,
  input  tlb_pkg::page_num_t       lookup_b_vpn,
  input  logic                     lookup_b_write,
  output logic                     result_b_valid,
  output logic                     result_b_hit,
  output logic                     result_b_fault,
  output tlb_pkg::page_num_t       result_b_ppn,
  output logic                     result_b_pcd
);

  import tlb_pkg::*;

  logic                     wr_en;
  tlb_idx_t                 wr_idx;
  logic                     wr_half;
  logic [`TLB_WB_DAT_W-1:0] wr_data;
  tlb_idx_t                 rd_idx   [`TLB_RD_PORTS];
  tlb_entry_t               rd_entry [`TLB_RD_PORTS];
  page_num_t                vpn_all  [`TLB_ENTRIES];
  logic [`TLB_ENTRIES-1:0]  valid_all;

  // ports 0 and 1 serve the lanes, port 2 the bus.
  tlb_table u_table (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_half   (wr_half),
    .wr_data   (wr_data),
    .rd_idx    (rd_idx),
    .rd_entry  (rd_entry),
    .vpn_all   (vpn_all),
    .valid_all (valid_all)
  );

  tlb_lookup lane_a (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (lookup_a_valid),
    .req_vpn   (lookup_a_vpn),
    .req_write (lookup_a_write),
    .vpn_all   (vpn_all),
    .valid_all (valid_all),
    .rd_idx    (rd_idx[0]),
    .rd_entry  (rd_entry[0]),
    .rsp_valid (result_a_valid),
    .rsp_hit   (result_a_hit),
    .rsp_fault (result_a_fault),
    .rsp_ppn   (result_a_ppn),
    .rsp_pcd   (result_a_pcd)
  );

  tlb_lookup lane_b (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (lookup_b_valid),
    .req_vpn   (lookup_b_vpn),
    .req_write (lookup_b_write),
    .vpn_all   (vpn_all),
    .valid_all (valid_all),
    .rd_idx    (rd_idx[1]),
    .rd_entry  (rd_entry[1]),
    .rsp_valid (result_b_valid),
    .rsp_hit   (result_b_hit),
    .rsp_fault (result_b_fault),
    .rsp_ppn   (result_b_ppn),
    .rsp_pcd   (result_b_pcd)
  );

  tlb_wb_slave u_wb_slave (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_half  (wr_half),
    .wr_data  (wr_data),
    .rd_idx   (rd_idx[2]),
    .rd_entry (rd_entry[2])
  );

endmodule

// ==== verif/tlb_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlb testbench
// random lookups and bus traffic checked
// against an entry-array model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlb_defines.svh"

module tlb_tb;

  import tlb_pkg::*;

  typedef struct packed {
    logic      valid;
    logic      hit;
    logic      fault;
    page_num_t ppn;
    logic      pcd;
  } result_t;

  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] SEED       = 32'h831b_21ca;
  localparam logic [31:0] LFSR_TAPS  = 32'ha300_0000;
  localparam page_num_t   DUP_BASE   = 20'h5a3c0;
  localparam int N_MISS = 24;
  localparam int N_RW   = 12;
  localparam int N_HIT  = 48;
  localparam int N_FLT  = 48;
  localparam int N_DUP  = 32;
  localparam int N_CONC = 64;
  localparam int BUS_OP = 8;
  localparam int FILL   = 2 * `TLB_ENTRIES * BUS_OP;
  localparam int TOTAL_CYCLES = 8 + N_MISS + 2 * N_RW * BUS_OP + 4 * FILL
                                + N_HIT + N_FLT + N_DUP + N_CONC + 16;

  logic clk = 1'b0;
  logic arst_n;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`TLB_WB_ADR_W-1:0] wb_adr;
  logic [`TLB_WB_DAT_W-1:0] wb_dat_w, wb_dat_r;
  logic lookup_a_valid, lookup_a_write, result_a_valid, result_a_hit;
  logic result_a_fault, result_a_pcd;
  logic lookup_b_valid, lookup_b_write, result_b_valid, result_b_hit;
  logic result_b_fault, result_b_pcd;
  page_num_t lookup_a_vpn, lookup_b_vpn, result_a_ppn, result_b_ppn;

  logic [31:0] lfsr = SEED;
  tlb_entry_t  model [`TLB_ENTRIES];
  result_t     exp_a [$];
  result_t     exp_b [$];

  tlb_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random bits and model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one galois step per bit taken.
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic void apply_write(input logic [3:0] adr, input logic [31:0] dat);
    tlb_idx_t idx;
    idx = adr[3:1];
    if (!adr[0]) begin
      model[idx].vpn = dat[19:0];
    end else begin
      model[idx].ppn = dat[19:0];
      {model[idx].valid, model[idx].pr, model[idx].rw, model[idx].pcd} = dat[23:20];
    end
  endfunction

  // vpn in half 0, flags and ppn in half 1.
  function automatic logic [31:0] expected_word(input logic [3:0] adr);
    tlb_entry_t e;
    e = model[adr[3:1]];
    if (!adr[0]) begin
      return {12'h0, e.vpn};
    end
    return {8'h0, e.valid, e.pr, e.rw, e.pcd, e.ppn};
  endfunction

  // lowest valid matching index wins.
  function automatic result_t expect_lookup(input page_num_t vpn, input logic wr,
                                            input logic v);
    result_t    r;
    logic       found;
    tlb_entry_t sel;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (!found && model[i].valid && model[i].vpn == vpn) begin
        found = 1'b1;
        sel   = model[i];
      end
    end
    r.valid = v;
    r.hit   = found;
    r.fault = !found || !sel.pr || (wr && !sel.rw);
    r.ppn   = found ? sel.ppn : '0;
    r.pcd   = found && sel.pcd;
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_page(input string name, input page_num_t got, input page_num_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "page mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_result(input string lane, input result_t got, input result_t exp);
    check_bit({"result_", lane, "_valid"}, got.valid, exp.valid);
    if (exp.valid) begin
      check_bit({"result_", lane, "_hit"}, got.hit, exp.hit);
      check_bit({"result_", lane, "_fault"}, got.fault, exp.fault);
      check_page({"result_", lane, "_ppn"}, got.ppn, exp.ppn);
      check_bit({"result_", lane, "_pcd"}, got.pcd, exp.pcd);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat);
    int waited;
    @(posedge clk);
    #1;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {1'b1, 1'b1, we, adr, dat};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 4);
    if (!wb_ack) begin
      $display("bus access to word %0d got no ack within 4 cycles", adr);
      $display("CHECKS FAILED");
      $fatal(1, "missing ack");
    end else begin
      if (!we) begin
        check_word("wb_dat_r", wb_dat_r, expected_word(adr));
      end
      @(posedge clk);
      #1;
      {wb_cyc, wb_stb, wb_we} = 3'b000;
      @(negedge clk);
      check_bit("wb_ack", wb_ack, 1'b0);
    end
  endtask

  // mode 0 random, 1 half from stored tags, 2 duplicate tags.
  function automatic page_num_t pick_vpn(input int mode);
    if (mode == 2) begin
      return DUP_BASE + page_num_t'(next_bits(1));
    end
    if (mode == 1 && next_bits(1) != 0) begin
      return model[tlb_idx_t'(next_bits(`TLB_IDX_W))].vpn;
    end
    return page_num_t'(next_bits(`TLB_PN_W));
  endfunction

  task automatic drive_lookups(input int n, input int mode, input logic always_valid);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #1;
      lookup_a_valid = always_valid | 1'(next_bits(1));
      lookup_a_vpn   = pick_vpn(mode);
      lookup_a_write = 1'(next_bits(1));
      lookup_b_valid = always_valid | 1'(next_bits(1));
      lookup_b_vpn   = pick_vpn(mode);
      lookup_b_write = 1'(next_bits(1));
    end
    @(posedge clk);
    #1;
    lookup_a_valid = 1'b0;
    lookup_b_valid = 1'b0;
  endtask

  task automatic fill_table(input logic force_valid, input logic dup_tags);
    page_num_t   vpn;
    logic [31:0] hi;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      vpn = dup_tags ? DUP_BASE + page_num_t'(next_bits(1))
                     : page_num_t'(next_bits(`TLB_PN_W));
      hi  = {8'h0, force_valid | 1'(next_bits(1)), 3'(next_bits(3)),
             page_num_t'(next_bits(`TLB_PN_W))};
      bus_access(1'b1, {i[2:0], 1'b0}, {12'h0, vpn});
      bus_access(1'b1, {i[2:0], 1'b1}, hi);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor, main, watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // inputs are stable at the falling edge before they are sampled.
  initial begin : monitor
    result_t e;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge clk);
      e = (exp_a.size() > 0) ? exp_a.pop_front() : '0;
      check_result("a", {result_a_valid, result_a_hit, result_a_fault, result_a_ppn,
                         result_a_pcd}, e);
      e = (exp_b.size() > 0) ? exp_b.pop_front() : '0;
      check_result("b", {result_b_valid, result_b_hit, result_b_fault, result_b_ppn,
                         result_b_pcd}, e);
      // a write lands on the same edge that samples the next request.
      if (wb_ack && wb_we) begin
        apply_write(wb_adr, wb_dat_w);
      end
      exp_a.push_back(expect_lookup(lookup_a_vpn, lookup_a_write, lookup_a_valid));
      exp_b.push_back(expect_lookup(lookup_b_vpn, lookup_b_write, lookup_b_valid));
    end
  end

  initial begin : main
    logic [3:0]  adr;
    logic [31:0] dat;
    arst_n = 1'b0;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
    {lookup_a_valid, lookup_a_vpn, lookup_a_write} = '0;
    {lookup_b_valid, lookup_b_vpn, lookup_b_write} = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
    drive_lookups(N_MISS, 0, 1'b0);
    for (int k = 0; k < N_RW; k++) begin
      adr = 4'(next_bits(4));
      dat = next_bits(32);
      bus_access(1'b1, adr, dat);
      bus_access(1'b0, adr, 32'h0);
    end
    fill_table(1'b0, 1'b0);
    drive_lookups(N_HIT, 1, 1'b0);
    fill_table(1'b1, 1'b0);
    drive_lookups(N_FLT, 1, 1'b0);
    fill_table(1'b1, 1'b1);
    drive_lookups(N_DUP, 2, 1'b1);
    fork
      drive_lookups(N_CONC, 1, 1'b1);
      fill_table(1'b0, 1'b0);
    join
    repeat (3) @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin : watchdog
    #(TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("simulation ran past its time budget, watchdog stopped it");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_table.sv
verilog/tlb_lookup.sv
verilog/tlb_wb_slave.sv
verilog/tlb_top.sv
verif/tlb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary
TOP       := tlb_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
